/* include/alu_config.svh */
// sizing for the alu; ALU_DATA_W must stay a power of two for the multiplier bit counter
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand word width
`define ALU_DATA_W 32

// every result is a high and a low word
`define ALU_RESULT_W (2 * `ALU_DATA_W)

// shift amount 0 to 3
`define ALU_SHAMT_W 2

// command queue entries, also the sender's starting command credits
`define ALU_CMD_DEPTH 4

// result credits held by the unit out of reset
`define ALU_RES_CREDITS 2

`endif

/* hdl/alu_op_pkg.sv */
// opcode encoding and datapath types; opcode values are fixed and shared with the stimulus file
`default_nettype none

`include "alu_config.svh"

package alu_op_pkg;

	typedef enum logic [3:0] {
		op_nop   = 4'h0,
		op_not_a = 4'h1,
		op_not_b = 4'h2,
		op_and   = 4'h3,
		op_or    = 4'h4,
		op_xor   = 4'h5,
		op_xnor  = 4'h6,
		op_lsl_a = 4'h7,
		op_lsl_b = 4'h8,
		op_lsr_a = 4'h9,
		op_lsr_b = 4'ha,
		op_asr_a = 4'hb,
		op_asr_b = 4'hc,
		op_add   = 4'hd,
		op_sub   = 4'he,
		op_mul   = 4'hf
	} alu_opcode_e;

	typedef logic [`ALU_DATA_W-1:0]   alu_word_t;
	typedef logic [`ALU_RESULT_W-1:0] alu_result_t;
	typedef logic [`ALU_SHAMT_W-1:0]  alu_shamt_t;

	// one word to a full result, top bit copied into the high word
	function automatic alu_result_t sext_word(input alu_word_t w);
		return {{`ALU_DATA_W{w[`ALU_DATA_W-1]}}, w};
	endfunction

endpackage

`default_nettype wire

/* hdl/alu_ctrl_pkg.sv */
// control-side state encodings and counter types, sized from the config header
`default_nettype none

`include "alu_config.svh"

package alu_ctrl_pkg;

	typedef enum logic {
		seq_idle,
		seq_mul_wait // parked until the multiplier reports done
	} seq_state_e;

	typedef enum logic {
		mul_idle,
		mul_run
	} mul_state_e;

	typedef logic [$clog2(`ALU_RES_CREDITS + 1)-1:0] credit_cnt_t;
	typedef logic [$clog2(`ALU_CMD_DEPTH + 1)-1:0]   queue_cnt_t;

endpackage

`default_nettype wire

/* hdl/alu_cmd_queue.sv */
// circular command queue; push only with a held credit, DEPTH capped at ALU_CMD_DEPTH by queue_cnt_t
`default_nettype none

`include "alu_config.svh"

module alu_cmd_queue import alu_op_pkg::*, alu_ctrl_pkg::*;
#(
	parameter int DEPTH = `ALU_CMD_DEPTH
)
(
	input  wire         clk,
	input  wire         arst_n,
	input  wire         push,
	input  wire alu_opcode_e push_opcode,
	input  wire alu_word_t   push_src_a,
	input  wire alu_word_t   push_src_b,
	input  wire alu_shamt_t  push_shamt,
	input  wire         pop,
	output logic        empty,
	output alu_opcode_e head_opcode,
	output alu_word_t   head_src_a,
	output alu_word_t   head_src_b,
	output alu_shamt_t  head_shamt,
	output logic        credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	queue_cnt_t       count;

	alu_opcode_e mem_opcode [DEPTH];
	alu_word_t   mem_src_a  [DEPTH];
	alu_word_t   mem_src_b  [DEPTH];
	alu_shamt_t  mem_shamt  [DEPTH];

	// wraps at DEPTH, so non power of two depths work
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty       = (count == '0);
	assign head_opcode = mem_opcode[rd_ptr];
	assign head_src_a  = mem_src_a[rd_ptr];
	assign head_src_b  = mem_src_b[rd_ptr];
	assign head_shamt  = mem_shamt[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem_opcode[wr_ptr] <= push_opcode;
			mem_src_a[wr_ptr]  <= push_src_a;
			mem_src_b[wr_ptr]  <= push_src_b;
			mem_shamt[wr_ptr]  <= push_shamt;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end
		else
		begin
			credit <= pop; // one credit back per entry freed
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/alu_logic_shift.sv */
// logic and shift ops, 32-bit value sign-extended to 64; arithmetic opcodes give zero here
`default_nettype none

module alu_logic_shift import alu_op_pkg::*;
(
	input  wire alu_opcode_e opcode,
	input  wire alu_word_t   src_a,
	input  wire alu_word_t   src_b,
	input  wire alu_shamt_t  shamt,
	output alu_result_t result
);

	alu_word_t sh_src; // operand picked by the _a/_b variant
	alu_word_t word;

	always_comb
	begin
		case (opcode)
			op_lsl_b, op_lsr_b, op_asr_b: sh_src = src_b;
			default:                      sh_src = src_a;
		endcase
	end

	always_comb
	begin
		case (opcode)
			op_not_a:
				word = ~src_a;
			op_not_b:
				word = ~src_b;
			op_and:
				word = src_a & src_b;
			op_or:
				word = src_a | src_b;
			op_xor:
				word = src_a ^ src_b;
			op_xnor:
				word = ~(src_a ^ src_b);
			op_lsl_a, op_lsl_b:
				word = sh_src << shamt;
			op_lsr_a, op_lsr_b:
				word = sh_src >> shamt;
			op_asr_a, op_asr_b:
				word = alu_word_t'($signed(sh_src) >>> shamt);
			default:
				word = '0; // nop, add, sub, mul
		endcase
	end

	// a nonzero logical right shift clears the top bit,
	// so sign extension yields the zero-extended result
	assign result = sext_word(word);

endmodule

`default_nettype wire

/* hdl/alu_cla_adder.sv */
// 64-bit adder, 4-bit lookahead groups with group carries rippled; carry out is not provided
`default_nettype none

`include "alu_config.svh"

module alu_cla_adder
(
	input  wire [`ALU_RESULT_W-1:0] a,
	input  wire [`ALU_RESULT_W-1:0] b,
	input  wire                     cin,
	output logic [`ALU_RESULT_W-1:0] sum
);

	localparam int NGRP = `ALU_RESULT_W / 4;

	logic [`ALU_RESULT_W-1:0] g;
	logic [`ALU_RESULT_W-1:0] p;
	logic [`ALU_RESULT_W-1:0] c;
	logic [NGRP-1:0]          gc; // carry into each group

	assign g     = a & b;
	assign p     = a ^ b;
	assign gc[0] = cin;

	for (genvar i = 0; i < NGRP; i++)
	begin : g_grp
		logic [3:0] gg;
		logic [3:0] pp;

		assign gg = g[4*i +: 4];
		assign pp = p[4*i +: 4];

		assign c[4*i]   = gc[i];
		assign c[4*i+1] = gg[0] | (pp[0] & gc[i]);
		assign c[4*i+2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & gc[i]);
		assign c[4*i+3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
			| (pp[2] & pp[1] & pp[0] & gc[i]);

		if (i < NGRP - 1)
		begin : g_next
			logic grp_g;
			logic grp_p;

			assign grp_g = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
				| (pp[3] & pp[2] & pp[1] & gg[0]);
			assign grp_p     = &pp;
			assign gc[i + 1] = grp_g | (grp_p & gc[i]);
		end
	end

	assign sum = p ^ c;

endmodule

`default_nettype wire

/* hdl/alu_multiplier.sv */
// signed shift-add multiplier; done comes ALU_DATA_W cycles after start, start ignored while busy
`default_nettype none

`include "alu_config.svh"

module alu_multiplier import alu_op_pkg::*, alu_ctrl_pkg::*;
(
	input  wire         clk,
	input  wire         arst_n,
	input  wire         start,
	input  wire alu_word_t src_a,
	input  wire alu_word_t src_b,
	output logic        done,
	output alu_result_t product
);

	localparam int CNT_W = $clog2(`ALU_DATA_W);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`ALU_DATA_W - 1);

	mul_state_e       state;
	logic [CNT_W-1:0] bit_cnt;
	alu_result_t      mcand;   // sign-extended A, shifted left each step
	alu_word_t        mplier;  // B, shifted right each step
	alu_result_t      acc;
	alu_result_t      partial;
	logic             load;
	logic             step;
	logic             last;

	assign load    = start && (state == mul_idle);
	assign step    = (state == mul_run);
	assign last    = step && (bit_cnt == LAST_BIT);
	assign partial = mplier[0] ? mcand : '0;
	assign product = acc;

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			// bit 0 is folded in while loading
			mcand  <= sext_word(src_a) << 1;
			mplier <= src_b >> 1;
			acc    <= src_b[0] ? sext_word(src_a) : '0;
		end
		else if (step)
		begin
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
			if (last)
				acc <= acc - partial; // sign bit weighs -2^(n-1)
			else
				acc <= acc + partial;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= mul_idle;
			bit_cnt <= '0;
			done    <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (load)
			begin
				state   <= mul_run;
				bit_cnt <= CNT_W'(1);
			end
			else if (step)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (last)
				begin
					state <= mul_idle;
					done  <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/alu_sequencer.sv */
// issue control; a result credit is reserved at pop time, so a finished result never stalls
`default_nettype none

`include "alu_config.svh"

module alu_sequencer import alu_op_pkg::*, alu_ctrl_pkg::*;
(
	input  wire         clk,
	input  wire         arst_n,
	input  wire         q_empty,
	input  wire alu_opcode_e q_opcode,
	input  wire alu_word_t   q_src_a,
	input  wire alu_word_t   q_src_b,
	output logic        q_pop,
	input  wire alu_result_t ls_result,
	output alu_result_t add_a,
	output alu_result_t add_b,
	output logic        add_cin,
	input  wire alu_result_t add_sum,
	output logic        mul_start,
	input  wire         mul_done,
	input  wire alu_result_t mul_product,
	input  wire         res_credit,
	output logic        result_valid,
	output alu_result_t result_data
);

	seq_state_e  state;
	credit_cnt_t credits;
	logic        is_mul;
	logic        is_sub;
	alu_result_t next_data;

	assign is_mul = (q_opcode == op_mul);
	assign is_sub = (q_opcode == op_sub);
	assign q_pop  = (state == seq_idle) && !q_empty && (credits != '0);

	assign mul_start = q_pop && is_mul;

	// subtract as a + ~b + 1 on the sign-extended operands
	assign add_a   = sext_word(q_src_a);
	assign add_b   = is_sub ? ~sext_word(q_src_b) : sext_word(q_src_b);
	assign add_cin = is_sub;

	always_comb
	begin
		case (q_opcode)
			op_add, op_sub: next_data = add_sum;
			default:        next_data = ls_result;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state        <= seq_idle;
			credits      <= credit_cnt_t'(`ALU_RES_CREDITS);
			result_valid <= 1'b0;
			result_data  <= '0;
		end
		else
		begin
			result_valid <= 1'b0;
			case ({q_pop, res_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			case (state)
				seq_idle:
				begin
					if (q_pop && is_mul)
						state <= seq_mul_wait;
					else if (q_pop)
					begin
						result_valid <= 1'b1;
						result_data  <= next_data;
					end
				end
				seq_mul_wait:
				begin
					if (mul_done)
					begin
						result_valid <= 1'b1;
						result_data  <= mul_product;
						state        <= seq_idle;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/alu_top.sv */
// alu top; sender may only assert cmd_valid while holding a command credit, results in order
`default_nettype none

module alu_top import alu_op_pkg::*;
(
	input  wire         clk,
	input  wire         arst_n,
	input  wire         cmd_valid,
	input  wire alu_opcode_e cmd_opcode,
	input  wire alu_word_t   cmd_src_a,
	input  wire alu_word_t   cmd_src_b,
	input  wire alu_shamt_t  cmd_shamt,
	output logic        cmd_credit,
	output logic        result_valid,
	output alu_result_t result_data,
	input  wire         res_credit
);

	// queue head, read combinationally by the datapath
	logic        q_empty;
	logic        q_pop;
	alu_opcode_e q_opcode;
	alu_word_t   q_src_a;
	alu_word_t   q_src_b;
	alu_shamt_t  q_shamt;

	alu_result_t ls_result;
	alu_result_t add_a;
	alu_result_t add_b;
	logic        add_cin;
	alu_result_t add_sum;

	logic        mul_start;
	logic        mul_done;
	alu_result_t mul_product;

	alu_cmd_queue u_queue (
		.clk         (clk),
		.arst_n      (arst_n),
		.push        (cmd_valid),
		.push_opcode (cmd_opcode),
		.push_src_a  (cmd_src_a),
		.push_src_b  (cmd_src_b),
		.push_shamt  (cmd_shamt),
		.pop         (q_pop),
		.empty       (q_empty),
		.head_opcode (q_opcode),
		.head_src_a  (q_src_a),
		.head_src_b  (q_src_b),
		.head_shamt  (q_shamt),
		.credit      (cmd_credit)
	);

	alu_sequencer u_seq (
		.clk          (clk),
		.arst_n       (arst_n),
		.q_empty      (q_empty),
		.q_opcode     (q_opcode),
		.q_src_a      (q_src_a),
		.q_src_b      (q_src_b),
		.q_pop        (q_pop),
		.ls_result    (ls_result),
		.add_a        (add_a),
		.add_b        (add_b),
		.add_cin      (add_cin),
		.add_sum      (add_sum),
		.mul_start    (mul_start),
		.mul_done     (mul_done),
		.mul_product  (mul_product),
		.res_credit   (res_credit),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

	alu_logic_shift u_ls (
		.opcode (q_opcode),
		.src_a  (q_src_a),
		.src_b  (q_src_b),
		.shamt  (q_shamt),
		.result (ls_result)
	);

	alu_cla_adder u_add (
		.a   (add_a),
		.b   (add_b),
		.cin (add_cin),
		.sum (add_sum)
	);

	// operands taken straight off the queue head at mul_start
	alu_multiplier u_mul (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (mul_start),
		.src_a   (q_src_a),
		.src_b   (q_src_b),
		.done    (mul_done),
		.product (mul_product)
	);

endmodule

`default_nettype wire

/* tests/tb_alu.sv */
// alu testbench; needs tests/alu_stim.txt relative to the run directory, stops at the first error
`default_nettype none

`include "alu_config.svh"

module tb_alu import alu_op_pkg::*, alu_ctrl_pkg::*;
();

	localparam string STIM_FILE     = "tests/alu_stim.txt";
	localparam int    SEND_TIMEOUT  = 2000;  // cycles to wait for a command credit
	localparam int    DRAIN_TIMEOUT = 20000; // cycles to wait for the last results
	localparam int    HOLD_CYCLES   = 40;    // cycles with every result credit withheld

	logic        clk;
	logic        arst_n;
	logic        cmd_valid;
	alu_opcode_e cmd_opcode;
	alu_word_t   cmd_src_a;
	alu_word_t   cmd_src_b;
	alu_shamt_t  cmd_shamt;
	logic        cmd_credit;
	logic        result_valid;
	alu_result_t result_data;
	logic        res_credit;

	// commands from the file, in file order
	alu_opcode_e op_q [$];
	alu_word_t   a_q [$];
	alu_word_t   b_q [$];
	alu_shamt_t  sh_q [$];
	alu_result_t file_exp_q [$];

	// results still owed by the DUT
	alu_result_t exp_q [$];
	string       name_q [$];

	int          cmd_credits = `ALU_CMD_DEPTH;
	int          res_held = `ALU_RES_CREDITS; // result credits the DUT should hold
	int          received = 0;
	int          total = 0;
	int          hold_count = 0;
	logic        withhold = 1'b1;
	logic [31:0] lcg_state = 32'd16814;
	logic [31:0] rnd;

	alu_top dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd_valid    (cmd_valid),
		.cmd_opcode   (cmd_opcode),
		.cmd_src_a    (cmd_src_a),
		.cmd_src_b    (cmd_src_b),
		.cmd_shamt    (cmd_shamt),
		.cmd_credit   (cmd_credit),
		.result_valid (result_valid),
		.result_data  (result_data),
		.res_credit   (res_credit)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_result(input string name, input alu_result_t expected,
		input alu_result_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_credit(input string name, input queue_cnt_t expected,
		input queue_cnt_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic read_stimulus();
		int          fd;
		int          n;
		string       line;
		logic [3:0]  f_op;
		alu_word_t   f_a;
		alu_word_t   f_b;
		alu_shamt_t  f_sh;
		alu_result_t f_exp;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file %s", STIM_FILE);
			stop_with_failure();
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
			begin
				if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_sh, f_exp) != 5)
				begin
					$display("malformed stimulus line: %s", line);
					stop_with_failure();
				end
				op_q.push_back(alu_opcode_e'(f_op));
				a_q.push_back(f_a);
				b_q.push_back(f_b);
				sh_q.push_back(f_sh);
				file_exp_q.push_back(f_exp);
			end
		end
		$fclose(fd);
	endtask

	// called just after a rising edge, returns just after a later one
	task automatic send_command(input int idx);
		int waited;

		waited = 0;
		while (cmd_credits == 0)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > SEND_TIMEOUT)
			begin
				$display("timed out waiting for a command credit before command %0d", idx);
				stop_with_failure();
			end
		end
		cmd_valid  = 1'b1;
		cmd_opcode = op_q[idx];
		cmd_src_a  = a_q[idx];
		cmd_src_b  = b_q[idx];
		cmd_shamt  = sh_q[idx];
		cmd_credits--;
		exp_q.push_back(file_exp_q[idx]);
		name_q.push_back($sformatf("cmd %0d %s", idx, op_q[idx].name()));
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	// outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (arst_n)
		begin
			if (cmd_credit)
			begin
				if (cmd_credits >= `ALU_CMD_DEPTH)
				begin
					$display("cmd_credit pulsed with every command credit already returned");
					stop_with_failure();
				end
				cmd_credits++;
			end
			if (result_valid)
			begin
				if (res_held == 0)
				begin
					$display("result_valid appeared while the DUT held no result credit");
					stop_with_failure();
				end
				if (exp_q.size() == 0)
				begin
					$display("result_valid appeared with no command outstanding");
					stop_with_failure();
				end
				check_result(name_q.pop_front(), exp_q.pop_front(), result_data);
				res_held--;
				received++;
			end
			if (withhold && res_held == 0)
			begin
				hold_count++;
				if (hold_count >= HOLD_CYCLES)
					withhold = 1'b0; // start handing credits back
			end
		end
	end

	// result credits go back on pseudo-random cycles
	always @(posedge clk)
	begin
		#1;
		res_credit = 1'b0;
		if (arst_n && !withhold && res_held < `ALU_RES_CREDITS)
		begin
			rnd = lcg_next();
			if (rnd[17:16] == 2'b00)
			begin
				res_credit = 1'b1;
				res_held++;
			end
		end
	end

	initial
	begin
		int i;
		int waited;

		clk        = 1'b0;
		arst_n     = 1'b0;
		cmd_valid  = 1'b0;
		cmd_opcode = op_nop;
		cmd_src_a  = '0;
		cmd_src_b  = '0;
		cmd_shamt  = '0;
		res_credit = 1'b0;

		read_stimulus();
		total = op_q.size();
		if (total == 0)
		begin
			$display("the stimulus file holds no commands");
			stop_with_failure();
		end

		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// quiet outputs before any command
		for (i = 0; i < 5; i++)
		begin
			@(negedge clk);
			if (result_valid || cmd_credit)
			begin
				$display("result_valid or cmd_credit went high before any command was sent");
				stop_with_failure();
			end
		end

		@(posedge clk);
		#1;
		for (i = 0; i < total; i++)
			send_command(i);

		waited = 0;
		while (received < total)
		begin
			@(negedge clk);
			waited++;
			if (waited > DRAIN_TIMEOUT)
			begin
				$display("timed out waiting for the last results");
				stop_with_failure();
			end
		end
		repeat (5) @(negedge clk); // a stray result or late credit would show up here

		// one credit back per command sent
		check_credit("command credits restored", queue_cnt_t'(`ALU_CMD_DEPTH),
			queue_cnt_t'(cmd_credits));

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/alu_stim.txt */
# opcode src_a src_b shamt expected_result, all hex
# one command per line, results come back in this order
0 12345678 9abcdef0 0 0000000000000000
1 0f0f0f0f 00000000 0 fffffffff0f0f0f0
2 00000000 80000001 0 000000007ffffffe
3 ff00ff00 f0f0f0f0 0 fffffffff000f000
4 12340000 00005678 0 0000000012345678
5 aaaaaaaa 55555555 0 ffffffffffffffff
6 0000ffff 00ff00ff 0 ffffffffff0000ff
f 00000003 00000007 0 0000000000000015
7 80000001 00000000 0 ffffffff80000001
7 10000001 00000000 3 ffffffff80000008
8 00000000 40000000 1 ffffffff80000000
9 80000000 00000000 0 ffffffff80000000
9 80000000 00000000 1 0000000040000000
a 00000000 ffffffff 3 000000001fffffff
b 80000000 00000000 2 ffffffffe0000000
b 7ffffff8 00000000 3 000000000fffffff
c 00000000 fffffffe 1 ffffffffffffffff
d 7fffffff 00000001 0 0000000080000000
d 80000000 80000000 0 ffffffff00000000
d ffffffff 00000005 0 0000000000000004
e 80000000 00000001 0 ffffffff7fffffff
e 00000005 00000007 0 fffffffffffffffe
e 7fffffff 80000000 0 00000000ffffffff
f ffffffff 00000005 0 fffffffffffffffb
f 80000000 80000000 0 4000000000000000
f 7fffffff 80000000 0 c000000080000000
f 12345678 fffffffe 0 ffffffffdb975310
d 00000010 fffffff0 0 0000000000000000

/* src.f */
+incdir+include
hdl/alu_op_pkg.sv
hdl/alu_ctrl_pkg.sv
hdl/alu_cmd_queue.sv
hdl/alu_logic_shift.sv
hdl/alu_cla_adder.sv
hdl/alu_multiplier.sv
hdl/alu_sequencer.sv
hdl/alu_top.sv
tests/tb_alu.sv

/* Bender.yml */
package:
  name: alu_unit

export_include_dirs:
  - include

sources:
  - files:
      - hdl/alu_op_pkg.sv
      - hdl/alu_ctrl_pkg.sv
      - hdl/alu_cmd_queue.sv
      - hdl/alu_logic_shift.sv
      - hdl/alu_cla_adder.sv
      - hdl/alu_multiplier.sv
      - hdl/alu_sequencer.sv
      - hdl/alu_top.sv
  - target: test
    files:
      - tests/tb_alu.sv
